// File: logic/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // --------------------
    // widths and counts
    localparam int unsigned CORE_ADDR_W = 30;
    localparam int unsigned INST_W      = 32;
    localparam int unsigned MEM_DATA_W  = 128;
    localparam int unsigned MEM_ADDR_W  = 28;

    localparam int unsigned SETS  = 4;
    localparam int unsigned WAYS  = 2;
    localparam int unsigned IDX_W = 2;
    localparam int unsigned WAY_W = 1;
    localparam int unsigned BEATS = 4;

    localparam int unsigned BEAT_W      = 2;
    localparam int unsigned WORD_SEL_W  = 2;
    localparam int unsigned LINE_WORD_W = 4;
    localparam int unsigned TAG_W       = CORE_ADDR_W - LINE_WORD_W - IDX_W;
    // set index followed by beat within the line
    localparam int unsigned BANK_ADDR_W = IDX_W + BEAT_W;

    // --------------------
    // shared types
    // core word address from the top is tag, set, beat and word in beat
    typedef logic [CORE_ADDR_W-1:0] core_addr_t;
    typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [IDX_W-1:0]       set_idx_t;
    typedef logic [WAY_W-1:0]       way_idx_t;
    typedef logic [BEAT_W-1:0]      beat_t;
    typedef logic [WAY_W-1:0]       lru_age_t;
    typedef logic [MEM_DATA_W-1:0]  beat_data_t;
    typedef logic [INST_W-1:0]      inst_t;

    // pending miss kept until the core gets its word
    typedef struct packed {
        logic       active;
        core_addr_t addr;
        way_idx_t   way;
    } miss_rec_t;

endpackage

`default_nettype wire

// File: logic/icache_lookup_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_lookup_if;

    icache_pkg::core_addr_t lookup_addr;
    logic                   touch_en;
    icache_pkg::way_idx_t   touch_way;
    logic                   inval_en;
    logic                   fill_done_en;
    icache_pkg::set_idx_t   fill_set;
    icache_pkg::way_idx_t   fill_way;
    icache_pkg::tag_t       fill_tag;

    // combinational results for lookup_addr
    logic                   hit;
    icache_pkg::way_idx_t   hit_way;
    icache_pkg::way_idx_t   victim_way;

    modport ctrl (
        output lookup_addr, touch_en, touch_way, inval_en,
        output fill_done_en, fill_set, fill_way, fill_tag,
        input  hit, hit_way, victim_way
    );

    modport store (
        input  lookup_addr, touch_en, touch_way, inval_en,
        input  fill_done_en, fill_set, fill_way, fill_tag,
        output hit, hit_way, victim_way
    );

endinterface

`default_nettype wire

// File: logic/icache_fill_if.sv
`timescale 1ns/1ns
`default_nettype none

interface icache_fill_if;

    // bank write side takes one beat per refill response
    logic                   wr_en;
    icache_pkg::way_idx_t   wr_way;
    icache_pkg::set_idx_t   wr_set;
    icache_pkg::beat_t      wr_beat;
    icache_pkg::beat_data_t wr_data;

    // read word comes back one cycle later
    icache_pkg::core_addr_t rd_addr;
    icache_pkg::way_idx_t   rd_way;
    icache_pkg::inst_t      rd_word;

    modport ctrl (
        output wr_en, wr_way, wr_set, wr_beat,
        output rd_addr, rd_way
    );

    modport store (
        input  wr_en, wr_way, wr_set, wr_beat, wr_data,
        input  rd_addr, rd_way,
        output rd_word
    );

endinterface

`default_nettype wire

// File: logic/icache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tag_store (
    input  logic           clk,
    input  logic           rst,
    icache_lookup_if.store lk
);

    logic                 valid [icache_pkg::WAYS][icache_pkg::SETS];
    icache_pkg::tag_t     tags  [icache_pkg::WAYS][icache_pkg::SETS];
    icache_pkg::lru_age_t age   [icache_pkg::WAYS][icache_pkg::SETS];

    icache_pkg::set_idx_t set_idx;
    icache_pkg::tag_t     tag_in;

    assign set_idx = lk.lookup_addr[icache_pkg::LINE_WORD_W +: icache_pkg::IDX_W];
    assign tag_in  = lk.lookup_addr[icache_pkg::CORE_ADDR_W-1 -: icache_pkg::TAG_W];

    // --------------------
    // lookup

    always_comb begin
        lk.hit        = 1'b0;
        lk.hit_way    = '0;
        lk.victim_way = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (valid[w][set_idx] && (tags[w][set_idx] == tag_in)) begin
                lk.hit     = 1'b1;
                lk.hit_way = icache_pkg::way_idx_t'(w);
            end
            // oldest way gets replaced
            if (age[w][set_idx] == icache_pkg::lru_age_t'(icache_pkg::WAYS - 1)) begin
                lk.victim_way = icache_pkg::way_idx_t'(w);
            end
        end
    end

    // --------------------
    // valid bits and ages

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < icache_pkg::WAYS; w++) begin
                for (int s = 0; s < icache_pkg::SETS; s++) begin
                    valid[w][s] <= 1'b0;
                    age[w][s]   <= icache_pkg::lru_age_t'(w);
                end
            end
        end else begin
            if (lk.touch_en) begin
                // younger ways age by one and the touched way becomes youngest
                for (int w = 0; w < icache_pkg::WAYS; w++) begin
                    if (age[w][set_idx] < age[lk.touch_way][set_idx]) begin
                        age[w][set_idx] <= icache_pkg::lru_age_t'(age[w][set_idx] + 1'b1);
                    end
                end
                age[lk.touch_way][set_idx] <= '0;
            end

            // victim line is dropped as soon as the miss is seen
            if (lk.inval_en) begin
                valid[lk.victim_way][set_idx] <= 1'b0;
            end

            if (lk.fill_done_en) begin
                valid[lk.fill_way][lk.fill_set] <= 1'b1;
            end
        end
    end

    // tag written together with the last refill beat
    always_ff @(posedge clk) begin
        if (lk.fill_done_en) begin
            tags[lk.fill_way][lk.fill_set] <= lk.fill_tag;
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_data_store.sv
`timescale 1ns/1ns
`default_nettype none

module icache_data_store (
    input  logic          clk,
    icache_fill_if.store  fs
);

    logic [icache_pkg::BANK_ADDR_W-1:0] bank_addr;
    icache_pkg::beat_data_t             rd_beat [icache_pkg::WAYS];
    logic [icache_pkg::WORD_SEL_W-1:0]  word_sel_q;
    icache_pkg::way_idx_t               way_q;

    // one address shared by all banks where the refill write wins
    always_comb begin
        if (fs.wr_en) begin
            bank_addr = {fs.wr_set, fs.wr_beat};
        end else begin
            bank_addr = {fs.rd_addr[icache_pkg::LINE_WORD_W +: icache_pkg::IDX_W],
                         fs.rd_addr[icache_pkg::WORD_SEL_W +: icache_pkg::BEAT_W]};
        end
    end

    // --------------------
    // per-way banks

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : gen_bank
        icache_pkg::beat_data_t bank [icache_pkg::SETS * icache_pkg::BEATS];

        always_ff @(posedge clk) begin
            if (fs.wr_en && (fs.wr_way == icache_pkg::way_idx_t'(w))) begin
                bank[bank_addr] <= fs.wr_data;
            end
            rd_beat[w] <= bank[bank_addr];
        end
    end

    // --------------------
    // word select

    // way and word follow the read by one cycle
    always_ff @(posedge clk) begin
        word_sel_q <= fs.rd_addr[icache_pkg::WORD_SEL_W-1:0];
        way_q      <= fs.rd_way;
    end

    assign fs.rd_word = rd_beat[way_q][word_sel_q * icache_pkg::INST_W +: icache_pkg::INST_W];

endmodule

`default_nettype wire

// File: logic/icache_refill_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module icache_refill_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  icache_pkg::core_addr_t req_addr_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output icache_pkg::mem_addr_t  mem_req_addr_o,
    input  logic                   mem_rsp_valid_i,
    output logic                   mem_rsp_ready_o,
    icache_lookup_if.ctrl          lk,
    icache_fill_if.ctrl            fs
);

    typedef enum logic [1:0] {
        ST_RESET,
        ST_READY,
        ST_MISS
    } state_t;

    state_t                 state;
    state_t                 state_nx;
    logic                   acc_valid;
    logic                   acc_hit;
    icache_pkg::core_addr_t acc_addr;
    icache_pkg::way_idx_t   acc_victim;
    icache_pkg::miss_rec_t  rec;
    icache_pkg::core_addr_t line_addr;
    icache_pkg::beat_t      issue_cnt;
    icache_pkg::beat_t      rcv_cnt;
    logic                   issue_done;
    logic                   rcv_done;
    logic                   accept;
    logic                   miss_now;
    logic                   replay;
    logic                   beat_out;
    logic                   beat_in;

    // --------------------
    // handshakes

    assign miss_now        = (state == ST_READY) && acc_valid && !acc_hit;
    assign replay          = (state == ST_MISS) && rcv_done;
    assign req_ready_o     = (state == ST_READY) && !(acc_valid && !acc_hit);
    assign accept          = req_valid_i && req_ready_o;
    // hit answers one cycle after acceptance and a miss after the replay read
    assign rsp_valid_o     = (state == ST_READY) && ((acc_valid && acc_hit) || rec.active);
    assign mem_req_valid_o = miss_now || ((state == ST_MISS) && !issue_done);
    assign beat_out        = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_ready_o = (state == ST_MISS) && !rcv_done;
    assign beat_in         = mem_rsp_valid_i && mem_rsp_ready_o;

    assign line_addr      = (state == ST_MISS) ? rec.addr : acc_addr;
    assign mem_req_addr_o = {line_addr[icache_pkg::CORE_ADDR_W-1:icache_pkg::LINE_WORD_W],
                             issue_cnt};

    // --------------------
    // state and counters

    always_comb begin
        state_nx = state;
        case (state)
            ST_RESET: state_nx = ST_READY;
            ST_READY: if (miss_now) state_nx = ST_MISS;
            ST_MISS:  if (rcv_done) state_nx = ST_READY;
            default:  state_nx = ST_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_RESET;
            acc_valid  <= 1'b0;
            rec        <= '0;
            issue_cnt  <= '0;
            issue_done <= 1'b0;
            rcv_cnt    <= '0;
            rcv_done   <= 1'b0;
        end else begin
            state     <= state_nx;
            acc_valid <= accept;

            if (miss_now) begin
                rec <= '{active: 1'b1, addr: acc_addr, way: acc_victim};
            end else if ((state == ST_READY) && rec.active) begin
                rec.active <= 1'b0;
            end

            // counters wrap back to zero after the fourth beat
            if (beat_out) begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == icache_pkg::beat_t'(icache_pkg::BEATS - 1)) begin
                    issue_done <= 1'b1;
                end
            end
            if (beat_in) begin
                rcv_cnt <= rcv_cnt + 1'b1;
                if (rcv_cnt == icache_pkg::beat_t'(icache_pkg::BEATS - 1)) begin
                    rcv_done <= 1'b1;
                end
            end
            if (replay) begin
                issue_done <= 1'b0;
                rcv_done   <= 1'b0;
            end
        end
    end

    // accepted request with its lookup result
    always_ff @(posedge clk) begin
        if (accept) begin
            acc_addr   <= req_addr_i;
            acc_hit    <= lk.hit;
            acc_victim <= lk.victim_way;
        end
    end

    // --------------------
    // tag store and bank control

    always_comb begin
        if (miss_now) begin
            lk.lookup_addr = acc_addr;
        end else if (state == ST_MISS) begin
            lk.lookup_addr = rec.addr;
        end else begin
            lk.lookup_addr = req_addr_i;
        end
    end

    assign lk.touch_en     = (accept && lk.hit) || replay;
    assign lk.touch_way    = replay ? rec.way : lk.hit_way;
    assign lk.inval_en     = miss_now;
    assign lk.fill_done_en = beat_in && (rcv_cnt == icache_pkg::beat_t'(icache_pkg::BEATS - 1));
    assign lk.fill_set     = rec.addr[icache_pkg::LINE_WORD_W +: icache_pkg::IDX_W];
    assign lk.fill_way     = rec.way;
    assign lk.fill_tag     = rec.addr[icache_pkg::CORE_ADDR_W-1 -: icache_pkg::TAG_W];

    assign fs.wr_en   = beat_in;
    assign fs.wr_way  = rec.way;
    assign fs.wr_set  = rec.addr[icache_pkg::LINE_WORD_W +: icache_pkg::IDX_W];
    assign fs.wr_beat = rcv_cnt;
    // replay reads the pending word from the freshly filled line
    assign fs.rd_addr = replay ? rec.addr : req_addr_i;
    assign fs.rd_way  = replay ? rec.way : lk.hit_way;

endmodule

`default_nettype wire

// File: logic/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

module icache_top (
    input  logic                   clk,
    input  logic                   rst,

    // core request and response
    input  logic                   req_valid_i,
    input  icache_pkg::core_addr_t req_addr_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output icache_pkg::inst_t      rsp_data_o,

    // memory request and response
    output logic                   mem_req_valid_o,
    input  logic                   mem_req_ready_i,
    output icache_pkg::mem_addr_t  mem_req_addr_o,
    input  logic                   mem_rsp_valid_i,
    input  icache_pkg::beat_data_t mem_rsp_data_i,
    output logic                   mem_rsp_ready_o
);

    icache_lookup_if lk ();
    icache_fill_if   fill ();

    // refill beats go straight into the banks
    assign fill.wr_data = mem_rsp_data_i;
    assign rsp_data_o   = fill.rd_word;

    icache_tag_store u_tag_store (
        .clk (clk),
        .rst (rst),
        .lk  (lk)
    );

    icache_data_store u_data_store (
        .clk (clk),
        .fs  (fill)
    );

    icache_refill_ctrl u_refill_ctrl (
        .clk             (clk),
        .rst             (rst),
        .req_valid_i     (req_valid_i),
        .req_addr_i      (req_addr_i),
        .req_ready_o     (req_ready_o),
        .rsp_valid_o     (rsp_valid_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_addr_o  (mem_req_addr_o),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .lk              (lk),
        .fs              (fill)
    );

endmodule

`default_nettype wire

// File: tests/icache_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module icache_asserts #(
    parameter logic [31:0] MEM_PATTERN = 32'h0
) (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_valid_i,
    input icache_pkg::core_addr_t req_addr_i,
    input logic                   req_ready_o,
    input logic                   rsp_valid_o,
    input icache_pkg::inst_t      rsp_data_o,
    input logic                   mem_req_valid_o,
    input logic                   mem_req_ready_i,
    input icache_pkg::mem_addr_t  mem_req_addr_o
);

    int unsigned            fail_cnt = 0;
    icache_pkg::core_addr_t pend [2];
    logic [1:0]             pend_cnt;

    // --------------------
    // accepted addresses with the oldest first
    always @(posedge clk) begin
        if (rst) begin
            pend_cnt <= '0;
        end else begin
            if (rsp_valid_o) begin
                pend[0] <= pend[1];
            end
            if (req_valid_i && req_ready_o) begin
                pend[pend_cnt[0] ^ rsp_valid_o] <= req_addr_i;
            end
            pend_cnt <= pend_cnt + 2'(req_valid_i && req_ready_o) - 2'(rsp_valid_o);
        end
    end

    // --------------------
    // properties
    assert property (@(posedge clk) disable iff (rst)
        rsp_valid_o |-> rsp_data_o == (32'(pend[0]) ^ MEM_PATTERN))
    else begin
        fail_cnt++;
        $error("response word does not match the pattern for the oldest address");
    end

    // a stalled beat request keeps its address
    assert property (@(posedge clk) disable iff (rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o))
    else begin
        fail_cnt++;
        $error("beat request changed while stalled");
    end

    assert property (@(posedge clk) disable iff (rst)
        rsp_valid_o |-> pend_cnt != 2'd0)
    else begin
        fail_cnt++;
        $error("response with no accepted request pending");
    end

endmodule

`default_nettype wire

// File: tests/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;

    localparam logic [31:0] MEM_PATTERN = 32'hA5C3_0F96;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   req_valid_i = 1'b0;
    icache_pkg::core_addr_t req_addr_i = '0;
    logic                   req_ready_o;
    logic                   rsp_valid_o;
    icache_pkg::inst_t      rsp_data_o;
    logic                   mem_req_valid_o;
    logic                   mem_req_ready_i = 1'b0;
    icache_pkg::mem_addr_t  mem_req_addr_o;
    logic                   mem_rsp_valid_i = 1'b0;
    icache_pkg::beat_data_t mem_rsp_data_i = '0;
    logic                   mem_rsp_ready_o;

    icache_pkg::mem_addr_t  beat_q [$];
    logic [15:0]            lfsr = 16'd14945;
    logic                   rsp_taken = 1'b0;
    int                     gap = 0;
    int                     req_seen = 0;
    int                     acc_seen = 0;
    int                     rsp_seen = 0;
    int                     cycles = 0;

    icache_top u_dut (.*);

    // same constant as MEM_PATTERN
    bind icache_top icache_asserts #(.MEM_PATTERN(32'hA5C3_0F96)) u_asserts (.*);

    initial begin
        forever #20 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[2:0], fb};
        end
        return r;
    endfunction

    // lane l holds word address {beat, l} xor the pattern
    function automatic icache_pkg::beat_data_t beat_of(input icache_pkg::mem_addr_t a);
        icache_pkg::beat_data_t d;
        for (int l = 0; l < 4; l++) begin
            d[l*32 +: 32] = 32'({a, 2'(l)}) ^ MEM_PATTERN;
        end
        return d;
    endfunction

    task automatic stop_failed();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            stop_failed();
        end
    endtask

    // --------------------
    // memory model
    always @(posedge clk) begin
        cycles++;
        rsp_taken = mem_rsp_valid_i && mem_rsp_ready_o;
        if (rsp_taken) begin
            void'(beat_q.pop_front());
        end
        if (mem_req_valid_o && mem_req_ready_i) begin
            // line aligned first beat, then one up per request
            check(int'(mem_req_addr_o), int'({req_addr_i[29:4], 2'(req_seen)}),
                  "beat request address");
            beat_q.push_back(mem_req_addr_o);
            req_seen++;
        end
        acc_seen += int'(req_valid_i && req_ready_o);
        rsp_seen += int'(rsp_valid_o);
    end

    always @(negedge clk) begin
        mem_req_ready_i = (take_bits(2) != 4'd0);
        if (rsp_taken) begin
            mem_rsp_valid_i = 1'b0;
            gap = int'(take_bits(2));
        end
        if (!mem_rsp_valid_i && beat_q.size() != 0) begin
            if (gap == 0) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_data_i  = beat_of(beat_q[0]);
            end else begin
                gap--;
            end
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_cnt != 0) begin
            $display("an assertion on the cache outputs failed");
            stop_failed();
        end
    end

    initial begin
        repeat (2000) @(posedge clk);
        $display("timeout: the tests did not finish within 2000 clock cycles");
        stop_failed();
    end

    // --------------------
    // core side
    task automatic fetch(input icache_pkg::core_addr_t addr);
        req_valid_i = 1'b1;
        req_addr_i  = addr;
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid_i = 1'b0;
    endtask

    task automatic access(input icache_pkg::core_addr_t addr, input int exp_reqs);
        int base;
        base = req_seen;
        fetch(addr);
        while (rsp_seen != acc_seen) begin
            @(negedge clk);
        end
        check(req_seen - base, exp_reqs, "beat requests for one access");
    endtask

    initial begin
        int                     c0;
        icache_pkg::core_addr_t miss_addr [12];

        // addresses drawn before the clock starts
        for (int i = 0; i < 12; i++) begin
            miss_addr[i] = {24'(i + 8), 2'(take_bits(2)), take_bits(4)};
        end

        repeat (2) begin
            @(negedge clk);
            check(int'({req_ready_o, rsp_valid_o, mem_req_valid_o, mem_rsp_ready_o}), 0,
                  "control outputs in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check(int'(req_ready_o), 1, "req_ready_o after the reset state");

        // first miss, then the whole line back to back
        access(30'h0000_0005, 4);
        c0 = cycles;
        for (int w = 0; w < 16; w++) begin
            fetch(icache_pkg::core_addr_t'(w));
        end
        check(cycles - c0, 16, "cycles for 16 hits");
        @(negedge clk);
        check(rsp_seen, acc_seen, "responses after the hits");
        check(req_seen, 4, "beat requests after the hits");

        // A, B and C share set 1
        access(30'h0000_0010, 4);
        access(30'h0000_0050, 4);
        access(30'h0000_0010, 0);
        access(30'h0000_0090, 4);
        access(30'h0000_0010, 0);
        access(30'h0000_0050, 4);

        // fresh tags always miss
        for (int i = 0; i < 12; i++) begin
            access(miss_addr[i], 4);
        end

        if (u_dut.u_asserts.fail_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("an assertion failed during the run");
            stop_failed();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
logic/icache_pkg.sv
logic/icache_lookup_if.sv
logic/icache_fill_if.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_refill_ctrl.sv
logic/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

// File: run.sh
#!/bin/sh
# build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f compile.f

# a failing run still shows its output
out=$(./obj_dir/Vicache_tb +verilator+error+limit+100 2>&1) || true
echo "$out"
if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
